//--- hw/sbuf_settings.svh
`ifndef SBUF_SETTINGS_SVH
`define SBUF_SETTINGS_SVH

// Queue pointer width, 3 gives 8 slots
`define SBUF_PTR_WIDTH 3

// Number of slots, one is kept free to tell full from empty
`define SBUF_DEPTH (1 << `SBUF_PTR_WIDTH)

// Head and tail start here after reset
`define SBUF_PTR_RESET {`SBUF_PTR_WIDTH{1'b0}}

`endif

//--- hw/sbuf_pkg.sv
`include "sbuf_settings.svh"

package sbuf_pkg;

	// Byte address on both ports
	typedef logic [31:0] sbuf_addr_t;

	// Read and write data word
	typedef logic [31:0] sbuf_data_t;

	// Access size: 0 byte, 1 halfword, 2 word
	typedef logic [1:0] sbuf_size_t;

	// Head and tail of the store queue
	typedef logic [`SBUF_PTR_WIDTH-1:0] sbuf_ptr_t;

	// One buffered store, 66 bits
	typedef struct packed {
		sbuf_size_t size;
		sbuf_addr_t addr;
		sbuf_data_t wdata;
	} sbuf_entry_t;

	// Owner of the memory port
	typedef enum logic [1:0] {
		SBUF_IDLE,
		SBUF_THRU,    // CPU read goes straight to memory
		SBUF_QUEUED   // Queue head is being written to memory
	} sbuf_state_t;

endpackage

//--- hw/sbuf_queue_if.sv
interface sbuf_queue_if;
	import sbuf_pkg::*;

	// Arbiter to queue
	logic push;
	sbuf_entry_t push_entry;
	logic pop;

	// Queue to arbiter
	sbuf_entry_t head_entry;
	logic full;
	logic empty;

	modport queue_side (
		input push,
		input push_entry,
		input pop,
		output head_entry,
		output full,
		output empty
	);

	modport arbiter_side (
		output push,
		output push_entry,
		output pop,
		input head_entry,
		input full,
		input empty
	);

endinterface

//--- hw/store_queue.sv
`include "sbuf_settings.svh"

module store_queue (
	input logic clk,
	input logic resetn,
	sbuf_queue_if.queue_side q
);
	import sbuf_pkg::*;

	sbuf_entry_t slots [`SBUF_DEPTH];
	sbuf_ptr_t head;
	sbuf_ptr_t tail;
	sbuf_ptr_t tail_next;
	logic do_push;
	logic do_pop;

	assign tail_next = tail + 1'b1;

	// One slot stays unused so full and empty differ
	assign q.full = (tail_next == head);
	assign q.empty = (tail == head);

	// Requests are ignored when they cannot be served
	assign do_push = q.push & ~q.full;
	assign do_pop = q.pop & ~q.empty;

	assign q.head_entry = slots[head];

	// Entry storage, written at the tail
	always_ff @(posedge clk) begin
		if (do_push) begin
			slots[tail] <= q.push_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tail <= `SBUF_PTR_RESET;
		end else if (do_push) begin
			tail <= tail_next;
		end
	end

	// Head moves once the memory has taken the store
	always_ff @(posedge clk) begin
		if (!resetn) begin
			head <= `SBUF_PTR_RESET;
		end else if (do_pop) begin
			head <= head + 1'b1;
		end
	end

endmodule

//--- hw/mem_req_handshake.sv
module mem_req_handshake (
	input logic clk,
	input logic resetn,
	input logic need_req,
	input logic addr_ok,
	input logic data_ok,
	output logic req
);

	// High between address acceptance and data_ok
	logic outstanding;
	logic addr_taken;

	// New request only while nothing is in flight
	assign req = need_req & ~outstanding;

	assign addr_taken = req & addr_ok;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			outstanding <= 1'b0;
		end else if (addr_taken) begin
			outstanding <= 1'b1;
		end else if (data_ok) begin
			// Data phase done, port is free again
			outstanding <= 1'b0;
		end
	end

endmodule

//--- hw/store_buffer_arbiter.sv
module store_buffer_arbiter (
	input logic clk,
	input logic resetn,

	// CPU side
	input logic cpu_req,
	input logic cpu_wr,
	input sbuf_pkg::sbuf_size_t cpu_size,
	input sbuf_pkg::sbuf_addr_t cpu_addr,
	input sbuf_pkg::sbuf_data_t cpu_wdata,
	output logic cpu_addr_ok,
	output logic cpu_data_ok,

	// Memory side
	input logic mem_addr_ok,
	input logic mem_data_ok,
	output logic mem_wr,
	output sbuf_pkg::sbuf_size_t mem_size,
	output sbuf_pkg::sbuf_addr_t mem_addr,
	output sbuf_pkg::sbuf_data_t mem_wdata,
	output logic mem_req,

	// Request handshake
	output logic need_req,
	input logic req,

	sbuf_queue_if.arbiter_side q
);
	import sbuf_pkg::*;

	sbuf_state_t state;
	sbuf_state_t state_next;
	logic rd_req;
	logic wr_req;
	logic drain_first;
	logic sel_queue;
	logic sel_thru;
	logic wr_accept;

	assign rd_req = cpu_req & ~cpu_wr;
	assign wr_req = cpu_req & cpu_wr;

	// Reads must not pass older stores, and a full queue takes no writes
	assign drain_first = (rd_req & ~q.empty) | q.full;

	always_comb begin
		state_next = state;
		case (state)
			SBUF_IDLE: begin
				if (drain_first) begin
					state_next = SBUF_QUEUED;
				end else if (rd_req) begin
					state_next = SBUF_THRU;
				end else if (!q.empty) begin
					state_next = SBUF_QUEUED;
				end
			end
			SBUF_THRU, SBUF_QUEUED: begin
				if (mem_data_ok) begin
					state_next = SBUF_IDLE;
				end
			end
			default: state_next = SBUF_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= SBUF_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Port owner for this cycle, IDLE hands over without a bubble
	assign sel_queue = (state == SBUF_QUEUED) |
		((state == SBUF_IDLE) & (state_next == SBUF_QUEUED));
	assign sel_thru = (state == SBUF_THRU) |
		((state == SBUF_IDLE) & (state_next == SBUF_THRU));

	assign need_req = (sel_queue & ~q.empty) | (sel_thru & rd_req);
	assign mem_req = req;

	always_comb begin
		if (sel_queue) begin
			mem_wr = 1'b1;
			mem_size = q.head_entry.size;
			mem_addr = q.head_entry.addr;
			mem_wdata = q.head_entry.wdata;
		end else begin
			// Read passes through
			mem_wr = 1'b0;
			mem_size = cpu_size;
			mem_addr = cpu_addr;
			mem_wdata = cpu_wdata;
		end
	end

	// Writes are taken at once unless the queue is full or a read is in flight
	assign wr_accept = wr_req & ~q.full & (state != SBUF_THRU);

	assign q.push = wr_accept;
	assign q.push_entry = '{size: cpu_size, addr: cpu_addr, wdata: cpu_wdata};
	assign q.pop = (state == SBUF_QUEUED) & mem_data_ok;

	assign cpu_addr_ok = wr_accept | (sel_thru & req & mem_addr_ok);
	assign cpu_data_ok = wr_accept | ((state == SBUF_THRU) & mem_data_ok);

endmodule

//--- hw/store_buffer_top.sv
module store_buffer_top (
	input logic clk,
	input logic resetn,

	// CPU data port
	input logic cpu_req,
	input logic cpu_wr,
	input sbuf_pkg::sbuf_size_t cpu_size,
	input sbuf_pkg::sbuf_addr_t cpu_addr,
	input sbuf_pkg::sbuf_data_t cpu_wdata,
	output sbuf_pkg::sbuf_data_t cpu_rdata,
	output logic cpu_addr_ok,
	output logic cpu_data_ok,

	// Memory port
	output logic mem_req,
	output logic mem_wr,
	output sbuf_pkg::sbuf_size_t mem_size,
	output sbuf_pkg::sbuf_addr_t mem_addr,
	output sbuf_pkg::sbuf_data_t mem_wdata,
	input sbuf_pkg::sbuf_data_t mem_rdata,
	input logic mem_addr_ok,
	input logic mem_data_ok
);

	logic need_req;
	logic req;

	sbuf_queue_if queue_bus ();

	// Read data is never buffered
	assign cpu_rdata = mem_rdata;

	store_queue u_queue (
		.clk(clk),
		.resetn(resetn),
		.q(queue_bus.queue_side)
	);

	store_buffer_arbiter u_arbiter (
		.clk(clk),
		.resetn(resetn),
		.cpu_req(cpu_req),
		.cpu_wr(cpu_wr),
		.cpu_size(cpu_size),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_addr_ok(cpu_addr_ok),
		.cpu_data_ok(cpu_data_ok),
		.mem_addr_ok(mem_addr_ok),
		.mem_data_ok(mem_data_ok),
		.mem_wr(mem_wr),
		.mem_size(mem_size),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_req(mem_req),
		.need_req(need_req),
		.req(req),
		.q(queue_bus.arbiter_side)
	);

	// One transaction in flight on the memory port
	mem_req_handshake u_req_hs (
		.clk(clk),
		.resetn(resetn),
		.need_req(need_req),
		.addr_ok(mem_addr_ok),
		.data_ok(mem_data_ok),
		.req(req)
	);

endmodule

//--- sim/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset held for the first 10 cycles
	initial begin
		resetn = 1'b0;
		repeat (10) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

//--- sim/sbuf_properties.sv
module sbuf_properties (
	input logic clk,
	input logic resetn,
	input logic cpu_req,
	input logic cpu_wr,
	input logic cpu_addr_ok,
	input logic cpu_data_ok,
	input logic mem_req,
	input logic mem_wr,
	input sbuf_pkg::sbuf_size_t mem_size,
	input sbuf_pkg::sbuf_addr_t mem_addr,
	input sbuf_pkg::sbuf_data_t mem_wdata,
	input logic mem_addr_ok,
	input logic mem_data_ok
);
	timeunit 1ns;
	timeprecision 100ps;

	// Address taken, data not yet returned
	logic in_flight;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			in_flight <= 1'b0;
		end else if (mem_req && mem_addr_ok) begin
			in_flight <= 1'b1;
		end else if (mem_data_ok) begin
			in_flight <= 1'b0;
		end
	end

	req_held: assert property (@(posedge clk) disable iff (!resetn)
		mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_size)
			&& $stable(mem_addr) && $stable(mem_wdata))
		else $error("mem_req dropped or changed before mem_addr_ok");

	one_in_flight: assert property (@(posedge clk) disable iff (!resetn)
		in_flight |-> !mem_req)
		else $error("mem_req raised before mem_data_ok");

	write_same_cycle: assert property (@(posedge clk) disable iff (!resetn)
		cpu_req && cpu_wr && cpu_addr_ok |-> cpu_data_ok)
		else $error("CPU write accepted without data_ok in the same cycle");

endmodule

bind store_buffer_top sbuf_properties u_props (.*);

//--- sim/tb_store_buffer.sv
`include "sbuf_settings.svh"

module tb_store_buffer;
	timeunit 1ns;
	timeprecision 100ps;
	import sbuf_pkg::*;

	localparam int TIMEOUT = 300;

	logic clk;
	logic resetn;
	logic cpu_req;
	logic cpu_wr;
	sbuf_size_t cpu_size;
	sbuf_addr_t cpu_addr;
	sbuf_data_t cpu_wdata;
	sbuf_data_t cpu_rdata;
	logic cpu_addr_ok;
	logic cpu_data_ok;
	logic mem_req;
	logic mem_wr;
	sbuf_size_t mem_size;
	sbuf_addr_t mem_addr;
	sbuf_data_t mem_wdata;
	sbuf_data_t mem_rdata = '0;
	logic mem_addr_ok = 1'b0;
	logic mem_data_ok = 1'b0;

	integer seed = 32'h3eeb_059b;
	int errors = 0;
	int timeouts = 0;
	int full_blocks = 0;

	// Model state
	sbuf_entry_t exp_writes [$];
	sbuf_data_t shadow [logic [29:0]];
	int in_queue = 0;
	logic rd_pending = 1'b0;
	sbuf_addr_t rd_addr;
	logic mem_wr_pending = 1'b0;

	// Responder state
	sbuf_data_t mem_words [logic [29:0]];
	logic stall = 1'b0;
	logic busy;
	int addr_wait;
	int data_wait;
	sbuf_entry_t cur;
	logic cur_wr;

	tb_clock u_clock (.clk(clk), .resetn(resetn));

	store_buffer_top u_dut (.*);

	// Unwritten words read back as a pattern of their own address
	function automatic sbuf_data_t fill_word(input logic [29:0] word);
		return {word, 2'b00} ^ 32'hc3a5_0f1e;
	endfunction

	function automatic sbuf_data_t merge_word(input sbuf_data_t old, input sbuf_size_t size,
		input sbuf_addr_t addr, input sbuf_data_t data);
		logic [3:0] lanes;
		sbuf_data_t res;
		case (size)
			2'd0: lanes = 4'b0001 << addr[1:0];
			2'd1: lanes = addr[1] ? 4'b1100 : 4'b0011;
			default: lanes = 4'b1111;
		endcase
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (lanes[i]) res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	task automatic check_addr(input string name, input sbuf_addr_t got, input sbuf_addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input sbuf_data_t got, input sbuf_data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_size(input string name, input sbuf_size_t got, input sbuf_size_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// Memory responder, random address and data delays
	always @(posedge clk) begin
		if (!resetn) begin
			mem_addr_ok <= 1'b0;
			mem_data_ok <= 1'b0;
			mem_rdata <= '0;
			busy <= 1'b0;
			addr_wait <= 0;
		end else begin
			mem_data_ok <= 1'b0;
			if (busy) begin
				if (data_wait == 0) begin
					mem_data_ok <= 1'b1;
					busy <= 1'b0;
					addr_wait <= $unsigned($random(seed)) % 4;
					if (cur_wr) begin
						mem_words[cur.addr[31:2]] = merge_word(mem_words.exists(cur.addr[31:2]) ?
							mem_words[cur.addr[31:2]] : fill_word(cur.addr[31:2]),
							cur.size, cur.addr, cur.wdata);
					end else begin
						mem_rdata <= mem_words.exists(cur.addr[31:2]) ?
							mem_words[cur.addr[31:2]] : fill_word(cur.addr[31:2]);
					end
				end else begin
					data_wait <= data_wait - 1;
				end
			end else if (mem_addr_ok && mem_req) begin
				mem_addr_ok <= 1'b0;
				busy <= 1'b1;
				cur <= '{size: mem_size, addr: mem_addr, wdata: mem_wdata};
				cur_wr <= mem_wr;
				data_wait <= $unsigned($random(seed)) % 4;
			end else if (!mem_addr_ok && !stall) begin
				if (addr_wait == 0) mem_addr_ok <= 1'b1;
				else addr_wait <= addr_wait - 1;
			end
		end
	end

	// Model and checks, sampled mid-cycle
	always @(negedge clk) begin
		logic exp_acc;
		sbuf_entry_t e;
		sbuf_data_t exp_rd;
		if (resetn) begin
			if (cpu_req && cpu_wr) begin
				exp_acc = (in_queue < `SBUF_DEPTH - 1);
				check_flag("cpu_addr_ok", cpu_addr_ok, exp_acc);
				check_flag("cpu_data_ok", cpu_data_ok, exp_acc);
				if (!exp_acc) full_blocks++;
				if (cpu_addr_ok) begin
					exp_writes.push_back('{size: cpu_size, addr: cpu_addr, wdata: cpu_wdata});
					shadow[cpu_addr[31:2]] = merge_word(shadow.exists(cpu_addr[31:2]) ?
						shadow[cpu_addr[31:2]] : fill_word(cpu_addr[31:2]),
						cpu_size, cpu_addr, cpu_wdata);
				end
			end
			if (cpu_req && !cpu_wr && cpu_addr_ok) begin
				rd_pending = 1'b1;
				rd_addr = cpu_addr;
			end
			// No read request may reach memory ahead of older stores
			if (mem_req && !mem_wr && in_queue != 0) begin
				$display("Memory read issued with %0d writes still undrained at %0d ns",
					in_queue, $time);
				errors++;
			end
			if (mem_req && mem_addr_ok) begin
				if (mem_wr) begin
					if (exp_writes.size() == 0) begin
						$display("Memory write seen with no CPU write left to drain at %0d ns",
							$time);
						errors++;
					end else begin
						e = exp_writes.pop_front();
						check_size("mem_size", mem_size, e.size);
						check_addr("mem_addr", mem_addr, e.addr);
						check_data("mem_wdata", mem_wdata, e.wdata);
					end
					mem_wr_pending = 1'b1;
				end else begin
					check_size("mem_size", mem_size, cpu_size);
					check_addr("mem_addr", mem_addr, cpu_addr);
				end
			end
			if (rd_pending && cpu_data_ok && !(cpu_req && cpu_wr)) begin
				exp_rd = shadow.exists(rd_addr[31:2]) ? shadow[rd_addr[31:2]] :
					fill_word(rd_addr[31:2]);
				check_data("cpu_rdata", cpu_rdata, exp_rd);
				rd_pending = 1'b0;
			end
			// Count updates after the acceptance check above
			if (cpu_req && cpu_wr && cpu_addr_ok) in_queue++;
			if (mem_data_ok && mem_wr_pending) begin
				in_queue--;
				mem_wr_pending = 1'b0;
			end
		end
	end

	task automatic run_op(input logic wr, input sbuf_size_t size, input sbuf_addr_t addr,
		input sbuf_data_t data);
		int n;
		logic seen;
		@(posedge clk);
		cpu_req <= 1'b1;
		cpu_wr <= wr;
		cpu_size <= size;
		cpu_addr <= addr;
		cpu_wdata <= data;
		n = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT) begin
			@(negedge clk);
			seen = cpu_addr_ok;
			n++;
		end
		if (!seen) begin
			$display("Timed out waiting for cpu_addr_ok at %0d ns", $time);
			timeouts++;
		end
		@(posedge clk);
		cpu_req <= 1'b0;
		if (!wr && seen) begin
			n = 0;
			while (rd_pending && n < TIMEOUT) begin
				@(posedge clk);
				n++;
			end
			if (rd_pending) begin
				$display("Timed out waiting for read data at %0d ns", $time);
				timeouts++;
			end
		end
	endtask

	task automatic random_op(input logic force_wr);
		logic wr;
		sbuf_size_t size;
		sbuf_addr_t addr;
		wr = force_wr | (($unsigned($random(seed)) % 10) < 7);
		size = sbuf_size_t'($unsigned($random(seed)) % 3);
		// Small address pool so reads hit recent writes
		addr = 32'h0000_1000 + (($unsigned($random(seed)) % 8) * 4);
		if (size == 2'd0) addr[1:0] = 2'($random(seed));
		else if (size == 2'd1) addr[1] = 1'($random(seed));
		run_op(wr, size, addr, $random(seed));
	endtask

	initial begin
		int n;
		int blocks_before;
		cpu_req <= 1'b0;
		cpu_wr <= 1'b0;
		cpu_size <= '0;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		n = 0;
		while (resetn !== 1'b1 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (resetn !== 1'b1) begin
			$display("Reset never released");
			timeouts++;
		end
		repeat (300) random_op(1'b0);
		// Hold the memory off so the queue fills up
		@(posedge clk);
		blocks_before = full_blocks;
		stall <= 1'b1;
		fork
			begin
				repeat (40) @(posedge clk);
				stall <= 1'b0;
			end
		join_none
		repeat (12) random_op(1'b1);
		if (full_blocks == blocks_before) begin
			$display("Queue never filled while memory was stalled");
			errors++;
		end
		repeat (60) random_op(1'b0);
		n = 0;
		while ((in_queue != 0 || exp_writes.size() != 0) && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (in_queue != 0 || exp_writes.size() != 0) begin
			$display("Queue did not drain, %0d writes left", in_queue);
			timeouts++;
		end
		repeat (20) begin
			@(negedge clk);
			check_flag("mem_req", mem_req, 1'b0);
		end
		$display("errors=%0d timeouts=%0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hw
hw/sbuf_pkg.sv
hw/sbuf_queue_if.sv
hw/store_queue.sv
hw/mem_req_handshake.sv
hw/store_buffer_arbiter.sv
hw/store_buffer_top.sv
sim/tb_clock.sv
sim/sbuf_properties.sv
sim/tb_store_buffer.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_store_buffer
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
